//--- Makefile
# Verilator build and run for the framebuffer read-request testbench

VERILATOR ?= verilator
TOP       ?= fbReadTopTb
OBJ_DIR   ?= obj_dir
FILE_LIST ?= vlog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Verification passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/fbReadPkg.sv
// Widths assume two 16-bit pixels per 32-bit memory word
// The register map has four word-sized registers and no read-back
package fbReadPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int AddrWidth = 32;
    localparam int PixelIdxWidth = 20;
    localparam int StreamWidth = 32;
    localparam int PixelWidth = 16;
    // Number of index bits that select a pixel inside one memory word
    localparam int PixelsPerWordLog = $clog2(StreamWidth / PixelWidth);
    localparam int TagWidth = PixelIdxWidth - PixelsPerWordLog;
    localparam int IdWidth = 8;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam int CfgAddrWidth = 2;
    localparam logic [CfgAddrWidth - 1 : 0] RegBase = 2'd0;
    localparam logic [CfgAddrWidth - 1 : 0] RegSpanStart = 2'd1;
    localparam logic [CfgAddrWidth - 1 : 0] RegSpanLength = 2'd2;
    localparam logic [CfgAddrWidth - 1 : 0] RegCommand = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // AXI read address constants
    //////////////////////////////////////////////////////////////////////

    // Log2 of the bytes in one word, also the shift from word tag to byte address
    localparam logic [2 : 0] ArSizeWord = 3'($clog2(StreamWidth / 8));
    localparam logic [1 : 0] ArBurstIncr = 2'b01;
    localparam logic [IdWidth - 1 : 0] ReadId = '0;

    // The tag names a memory word, the offset names a pixel inside it
    typedef struct packed {
        logic [TagWidth - 1 : 0]         tag;
        logic [PixelsPerWordLog - 1 : 0] offset;
    } pixelWord_t;

    // One pixel index, seen either as a flat count or split by memory word
    typedef union packed {
        logic [PixelIdxWidth - 1 : 0] flat;
        pixelWord_t                   word;
    } pixelIdx_t;

endpackage

//--- common/fetchIf.sv
// Pixel fetch stream between the span sequencer and the request generator
// The sequencer holds valid, dest and last until the transfer
`timescale 1ns/1ps

interface fetchIf;
    import fbReadPkg::*;

    // Driven by the sequencer
    logic      valid;
    logic      last;
    pixelIdx_t dest;

    // Driven by the request generator
    logic      ready;

    modport sequencer (
        output valid,
        output last,
        output dest,
        input  ready
    );

    modport generator (
        input  valid,
        input  last,
        input  dest,
        output ready
    );

endinterface

//--- common/memReadIf.sv
// AXI read address channel only, no read data channel
// Requests are single beat, arlen is always zero
`timescale 1ns/1ps

interface memReadIf;
    import fbReadPkg::*;

    logic [IdWidth - 1 : 0]   arid;
    logic [AddrWidth - 1 : 0] araddr;
    logic [7 : 0]             arlen;
    logic [2 : 0]             arsize;
    logic [1 : 0]             arburst;
    logic                     arvalid;
    logic                     arready;

    modport master (
        output arid,
        output araddr,
        output arlen,
        output arsize,
        output arburst,
        output arvalid,
        input  arready
    );

    modport slave (
        input  arid,
        input  araddr,
        input  arlen,
        input  arsize,
        input  arburst,
        input  arvalid,
        output arready
    );

endinterface

//--- memReadRequestGenerator/memReadRequestGenerator.sv
// One single-beat read per memory word touched by consecutive fetches
// Holds at most one queued request plus one skid fetch, ready drops meanwhile
`timescale 1ns/1ps

module memReadRequestGenerator (
    input  logic                                 aclk,
    input  logic                                 resetn,
    input  logic [fbReadPkg::AddrWidth - 1 : 0]  baseAddr,
    output logic                                 requestDone,
    fetchIf.generator                            fetch,
    memReadIf.master                             mem
);
    import fbReadPkg::*;

    // Tag of the word the current run of fetches falls in
    logic [TagWidth - 1 : 0] lastTag;
    // Becomes set after the first fetch of a stream has loaded lastTag
    logic                    fetchEnabled;
    // Last fetch of the stream has been taken, the final request is still due
    logic                    lastFetch;

    // Fetch parked while a request waits in the queue
    logic [TagWidth - 1 : 0] skidTag;
    logic                    skidLast;

    // One-entry queue in front of the address register
    logic                    memRequest;
    logic [TagWidth - 1 : 0] memRequestTag;
    logic                    memRequestFinal;
    // The request in the address register closes the stream
    logic                    arFinal;

    // An accepted fetch leaves the word of the previous one
    logic                    newTag;

    assign newTag = fetchEnabled && (fetch.dest.word.tag != lastTag);

    // Every read is one aligned word
    assign mem.arid = ReadId;
    assign mem.arlen = 8'd0;
    assign mem.arsize = ArSizeWord;
    assign mem.arburst = ArBurstIncr;

    assign requestDone = mem.arvalid && mem.arready && arFinal;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            lastTag <= '0;
            fetchEnabled <= 1'b0;
            lastFetch <= 1'b0;
            skidTag <= '0;
            skidLast <= 1'b0;
            memRequest <= 1'b0;
            memRequestFinal <= 1'b0;
            arFinal <= 1'b0;
            mem.arvalid <= 1'b0;
            fetch.ready <= 1'b1;
        end
        else
        begin
            //////////////////////////////////////////////////////////////
            // Address register
            //////////////////////////////////////////////////////////////

            if (!mem.arvalid)
            begin
                // Move the queued request out, the tag becomes a byte address
                if (memRequest)
                begin
                    mem.arvalid <= 1'b1;
                    mem.araddr <= baseAddr + (AddrWidth'(memRequestTag) << ArSizeWord);
                    arFinal <= memRequestFinal;
                    memRequest <= 1'b0;
                end
            end
            else if (mem.arready)
            begin
                mem.arvalid <= 1'b0;
            end

            //////////////////////////////////////////////////////////////
            // Fetch merging
            //////////////////////////////////////////////////////////////

            if (fetch.ready)
            begin
                if (fetch.valid)
                begin
                    fetchEnabled <= 1'b1;
                    if (newTag && memRequest)
                    begin
                        // The queue is full, park the fetch and stall the stream
                        fetch.ready <= 1'b0;
                        skidTag <= fetch.dest.word.tag;
                        skidLast <= fetch.last;
                    end
                    else
                    begin
                        // Crossing into a new word closes the previous one
                        if (newTag)
                        begin
                            memRequestTag <= lastTag;
                            memRequestFinal <= 1'b0;
                            memRequest <= 1'b1;
                        end
                        lastTag <= fetch.dest.word.tag;
                        // The word of the last fetch is requested while stalled
                        if (fetch.last)
                        begin
                            lastFetch <= 1'b1;
                            fetch.ready <= 1'b0;
                        end
                    end
                end
            end
            else if (!memRequest)
            begin
                if (lastFetch && memRequestFinal)
                begin
                    // Final request has entered the address register, reopen for the next stream
                    lastFetch <= 1'b0;
                    memRequestFinal <= 1'b0;
                    skidLast <= 1'b0;
                    fetch.ready <= 1'b1;
                end
                else
                begin
                    memRequestTag <= lastTag;
                    memRequest <= 1'b1;
                    memRequestFinal <= lastFetch;
                    if (lastFetch)
                    begin
                        // Next stream starts without a previous tag
                        fetchEnabled <= 1'b0;
                    end
                    else
                    begin
                        // Replay the parked fetch as the current word
                        lastTag <= skidTag;
                        lastFetch <= skidLast;
                        fetch.ready <= !skidLast;
                    end
                end
            end
        end
    end

    // AXI requires a pending address to stay put until the slave takes it
    arHold: assert property (@(posedge aclk) disable iff (!resetn)
        mem.arvalid && !mem.arready |=> mem.arvalid && $stable(mem.araddr))
        else $error("araddr or arvalid changed before arready");

    // Only single-beat reads go out on the bus
    arSingleBeat: assert property (@(posedge aclk) disable iff (!resetn)
        mem.arvalid |-> mem.arlen == 8'd0)
        else $error("arlen is not zero");

endmodule

//--- tb/fbReadTopTb.sv
// Acts as the register master and the AXI read address slave of fbReadTop
// Only request addresses are modeled as there is no read data channel
`timescale 1ns/1ps

module fbReadTopTb;
    import fbReadPkg::*;

    localparam int PixelsPerWord = StreamWidth / PixelWidth;
    localparam int BytesPerWord = StreamWidth / 8;
    localparam int ExpectedSize = $clog2(BytesPerWord);
    // Pixels over all spans that the tests run
    localparam int TotalSpanPixels = 8 + 4 + 1 + 40 + 16 + 16;
    localparam int TimeoutCycles = TotalSpanPixels * 8 + 200;

    logic                        aclk;
    logic                        resetn;
    logic                        cfgWrite;
    logic [CfgAddrWidth - 1 : 0] cfgAddr;
    logic [AddrWidth - 1 : 0]    cfgWdata;
    logic                        busy;
    logic                        spanDone;
    logic [IdWidth - 1 : 0]      arId;
    logic [AddrWidth - 1 : 0]    arAddr;
    logic [7 : 0]                arLen;
    logic [2 : 0]                arSize;
    logic [1 : 0]                arBurst;
    logic                        arValid;
    logic                        arReady;

    // Slave side state where arReady is random only while randomReady is set
    logic                        randomReady;
    logic [31 : 0]               lfsrState;
    // Addresses of accepted requests in handshake order
    logic [AddrWidth - 1 : 0]    gotAddrs[$];
    int                          doneCount;
    int                          monitorErrors;
    logic                        holdPending;
    logic [AddrWidth - 1 : 0]    heldAddr;

    int                          checkErrors;
    int                          testsRun;
    int                          testsFailed;
    int                          cycleCount;

    fbReadTop fbReadTop_i (
        .aclk     (aclk),
        .resetn   (resetn),
        .cfgWrite (cfgWrite),
        .cfgAddr  (cfgAddr),
        .cfgWdata (cfgWdata),
        .busy     (busy),
        .spanDone (spanDone),
        .arId     (arId),
        .arAddr   (arAddr),
        .arLen    (arLen),
        .arSize   (arSize),
        .arBurst  (arBurst),
        .arValid  (arValid),
        .arReady  (arReady)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Galois form where the low bit is the one that shifts out
    function automatic logic [31 : 0] nextLfsr(input logic [31 : 0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    function automatic int errorTotal();
        return checkErrors + monitorErrors;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Address slave and bus monitor
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        lfsrState = 32'h25a4;
        arReady = 1'b0;
        forever
        begin
            @(posedge aclk);
            if (randomReady)
            begin
                arReady <= lfsrState[0];
                lfsrState = nextLfsr(lfsrState);
            end
            else
            begin
                arReady <= 1'b1;
            end
        end
    end

    task automatic monitorCheck(input string name, input logic [31 : 0] expected,
                                input logic [31 : 0] actual);
        assert (actual == expected)
        else
        begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
            monitorErrors++;
        end
    endtask

    // Sampled mid cycle so the values here are what the next rising edge sees
    initial
    begin
        doneCount = 0;
        monitorErrors = 0;
        holdPending = 1'b0;
        heldAddr = '0;
        forever
        begin
            @(negedge aclk);
            // A refused request has to come back unchanged
            if (holdPending)
            begin
                monitorCheck("arValid", 32'd1, 32'(arValid));
                monitorCheck("arAddr", heldAddr, arAddr);
            end
            if (arValid && arReady)
            begin
                gotAddrs.push_back(arAddr);
                monitorCheck("arLen", 32'd0, 32'(arLen));
                monitorCheck("arSize", ExpectedSize, 32'(arSize));
                // INCR burst type
                monitorCheck("arBurst", 32'd1, 32'(arBurst));
                monitorCheck("arId", 32'(ReadId), 32'(arId));
            end
            holdPending = arValid && !arReady;
            heldAddr = arAddr;
            if (spanDone)
            begin
                doneCount++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helper tasks
    //////////////////////////////////////////////////////////////////////

    task automatic expectValue(input string name, input logic [31 : 0] expected,
                               input logic [31 : 0] actual);
        assert (actual == expected)
        else
        begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            checkErrors++;
        end
    endtask

    // The write lands on the second edge where cfgWrite is high
    task automatic writeReg(input logic [CfgAddrWidth - 1 : 0] addr,
                            input logic [AddrWidth - 1 : 0] data);
        @(posedge aclk);
        cfgWrite <= 1'b1;
        cfgAddr <= addr;
        cfgWdata <= data;
        @(posedge aclk);
        cfgWrite <= 1'b0;
    endtask

    task automatic startSpan(input logic [AddrWidth - 1 : 0] base, input int startIdx,
                             input int len);
        writeReg(RegBase, base);
        writeReg(RegSpanStart, startIdx);
        writeReg(RegSpanLength, len);
        writeReg(RegCommand, 32'd0);
    endtask

    // Returns a few cycles after the spanDone pulse
    task automatic waitSpanDone();
        @(negedge aclk);
        while (!spanDone)
        begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);
    endtask

    // One request per distinct word tag in the order the span walks them
    task automatic checkRequests(input logic [AddrWidth - 1 : 0] base, input int startIdx,
                                 input int len, input int firstIdx);
        logic [AddrWidth - 1 : 0] expected[$];
        int tag;
        int prevTag;
        int i;
        prevTag = -1;
        for (i = startIdx; i < startIdx + len; i++)
        begin
            tag = i / PixelsPerWord;
            if (tag != prevTag)
            begin
                expected.push_back(base + tag * BytesPerWord);
            end
            prevTag = tag;
        end
        expectValue("request count", expected.size(), gotAddrs.size() - firstIdx);
        for (i = 0; i < expected.size() && firstIdx + i < gotAddrs.size(); i++)
        begin
            assert (gotAddrs[firstIdx + i] == expected[i])
            else
            begin
                $display("error at %0t: arAddr of request %0d expected %h got %h",
                         $time, i, expected[i], gotAddrs[firstIdx + i]);
                checkErrors++;
            end
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        int errors;
        @(posedge aclk);
        errors = errorTotal() - errorsBefore;
        testsRun++;
        if (errors == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic testResetState();
        int errorsBefore;
        errorsBefore = errorTotal();
        @(negedge aclk);
        expectValue("arValid", 0, 32'(arValid));
        expectValue("busy", 0, 32'(busy));
        expectValue("spanDone", 0, 32'(spanDone));
        finishTest("reset state", errorsBefore);
    endtask

    task automatic testAlignedSpan();
        int errorsBefore;
        int firstIdx;
        int donesBefore;
        errorsBefore = errorTotal();
        firstIdx = gotAddrs.size();
        donesBefore = doneCount;
        startSpan(32'h1000_0000, 0, 8);
        waitSpanDone();
        checkRequests(32'h1000_0000, 0, 8, firstIdx);
        expectValue("spanDone count", 1, doneCount - donesBefore);
        expectValue("busy", 0, 32'(busy));
        finishTest("aligned span", errorsBefore);
    endtask

    task automatic testOddSpans();
        int errorsBefore;
        int firstIdx;
        errorsBefore = errorTotal();
        firstIdx = gotAddrs.size();
        startSpan(32'h2000_0100, 3, 4);
        waitSpanDone();
        checkRequests(32'h2000_0100, 3, 4, firstIdx);
        // Single pixel in the odd half of a word
        firstIdx = gotAddrs.size();
        startSpan(32'h2000_0100, 5, 1);
        waitSpanDone();
        checkRequests(32'h2000_0100, 5, 1, firstIdx);
        finishTest("unaligned and odd spans", errorsBefore);
    endtask

    task automatic testBackPressure();
        int errorsBefore;
        int firstIdx;
        errorsBefore = errorTotal();
        firstIdx = gotAddrs.size();
        randomReady <= 1'b1;
        startSpan(32'h3000_0000, 7, 40);
        waitSpanDone();
        randomReady = 1'b0;
        checkRequests(32'h3000_0000, 7, 40, firstIdx);
        finishTest("back-pressure", errorsBefore);
    endtask

    task automatic testCommandWhileBusy();
        int errorsBefore;
        int firstIdx;
        int donesBefore;
        errorsBefore = errorTotal();
        firstIdx = gotAddrs.size();
        donesBefore = doneCount;
        startSpan(32'h0004_0000, 9, 16);
        while (!busy)
        begin
            @(negedge aclk);
        end
        // All of these land while the first span still runs
        startSpan(32'h0009_0000, 100, 3);
        expectValue("busy", 1, 32'(busy));
        waitSpanDone();
        // Leave room for a stray span to show up in the counts
        repeat (6) @(negedge aclk);
        checkRequests(32'h0004_0000, 9, 16, firstIdx);
        expectValue("spanDone count", 1, doneCount - donesBefore);
        expectValue("busy", 0, 32'(busy));
        // Only the base is rewritten so the span keeps its first start and length
        firstIdx = gotAddrs.size();
        writeReg(RegBase, 32'h000a_0000);
        writeReg(RegCommand, 32'd0);
        waitSpanDone();
        checkRequests(32'h000a_0000, 9, 16, firstIdx);
        finishTest("command while busy", errorsBefore);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        resetn = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        cfgWdata = '0;
        randomReady = 1'b0;
        checkErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (3) @(posedge aclk);
        resetn <= 1'b1;
        testResetState();
        testAlignedSpan();
        testOddSpans();
        testBackPressure();
        testCommandWhileBusy();
        @(posedge aclk);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 testsRun, testsFailed, errorTotal());
        if (testsFailed == 0 && errorTotal() == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles)
        begin
            @(posedge aclk);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- verilog/fbReadConfig.sv
// Register writes to base and span are dropped while a span runs
// A command with a zero span length does not start anything
`timescale 1ns/1ps

module fbReadConfig (
    input  logic                                   aclk,
    input  logic                                   resetn,
    input  logic                                   cfgWrite,
    input  logic [fbReadPkg::CfgAddrWidth - 1 : 0] cfgAddr,
    input  logic [fbReadPkg::AddrWidth - 1 : 0]    cfgWdata,
    input  logic                                   busy,
    output logic [fbReadPkg::AddrWidth - 1 : 0]    baseAddr,
    output fbReadPkg::pixelIdx_t                   spanStart,
    output logic [fbReadPkg::PixelIdxWidth - 1 : 0] spanLength,
    output logic                                   start
);
    import fbReadPkg::*;

    // A start pulse in flight counts as busy, the sequencer sees it one edge later
    logic locked;

    assign locked = busy || start;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            baseAddr <= '0;
            spanStart <= '0;
            spanLength <= '0;
            start <= 1'b0;
        end
        else
        begin
            // Start is a single cycle pulse
            start <= 1'b0;
            if (cfgWrite && !locked)
            begin
                case (cfgAddr)
                    RegBase:       baseAddr <= cfgWdata;
                    RegSpanStart:  spanStart.flat <= cfgWdata[PixelIdxWidth - 1 : 0];
                    RegSpanLength: spanLength <= cfgWdata[PixelIdxWidth - 1 : 0];
                    // The data word of a command write carries nothing
                    RegCommand:    start <= (spanLength != '0);
                    default:       start <= 1'b0;
                endcase
            end
        end
    end

    // The sequencer must never be told to start while it is still running a span
    startWhileBusy: assert property (@(posedge aclk) disable iff (!resetn)
        start |-> !busy)
        else $error("start pulse while the sequencer is busy");

endmodule

//--- verilog/fbReadTop.sv
// Read address side only, read data is taken by an external consumer
// One span runs at a time, busy covers it until the final request is accepted
`timescale 1ns/1ps

module fbReadTop (
    input  logic                                   aclk,
    input  logic                                   resetn,

    // Register port
    input  logic                                   cfgWrite,
    input  logic [fbReadPkg::CfgAddrWidth - 1 : 0] cfgAddr,
    input  logic [fbReadPkg::AddrWidth - 1 : 0]    cfgWdata,

    // Status
    output logic                                   busy,
    output logic                                   spanDone,

    // AXI read address channel
    output logic [fbReadPkg::IdWidth - 1 : 0]      arId,
    output logic [fbReadPkg::AddrWidth - 1 : 0]    arAddr,
    output logic [7 : 0]                           arLen,
    output logic [2 : 0]                           arSize,
    output logic [1 : 0]                           arBurst,
    output logic                                   arValid,
    input  logic                                   arReady
);
    // Configuration seen by the sequencer and the generator
    logic [fbReadPkg::AddrWidth - 1 : 0]     baseAddr;
    fbReadPkg::pixelIdx_t                    spanStart;
    logic [fbReadPkg::PixelIdxWidth - 1 : 0] spanLength;
    logic                                    start;
    // Final request of the span has handshaked
    logic                                    requestDone;

    fetchIf   fetchBus ();
    memReadIf memBus ();

    fbReadConfig fbReadConfig_i (
        .aclk       (aclk),
        .resetn     (resetn),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgWdata   (cfgWdata),
        .busy       (busy),
        .baseAddr   (baseAddr),
        .spanStart  (spanStart),
        .spanLength (spanLength),
        .start      (start)
    );

    spanFetchSequencer spanFetchSequencer_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .start       (start),
        .spanStart   (spanStart),
        .spanLength  (spanLength),
        .requestDone (requestDone),
        .busy        (busy),
        .spanDone    (spanDone),
        .fetch       (fetchBus.sequencer)
    );

    memReadRequestGenerator memReadRequestGenerator_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .baseAddr    (baseAddr),
        .requestDone (requestDone),
        .fetch       (fetchBus.generator),
        .mem         (memBus.master)
    );

    // Flatten the address channel onto plain ports
    assign arId = memBus.arid;
    assign arAddr = memBus.araddr;
    assign arLen = memBus.arlen;
    assign arSize = memBus.arsize;
    assign arBurst = memBus.arburst;
    assign arValid = memBus.arvalid;
    assign memBus.arready = arReady;

endmodule

//--- verilog/spanFetchSequencer.sv
// Emits one pixel index per accepted cycle, from spanStart for spanLength pixels
// spanLength is nonzero on start, the register block guarantees it
`timescale 1ns/1ps

module spanFetchSequencer (
    input  logic                                    aclk,
    input  logic                                    resetn,
    input  logic                                    start,
    input  fbReadPkg::pixelIdx_t                    spanStart,
    input  logic [fbReadPkg::PixelIdxWidth - 1 : 0] spanLength,
    input  logic                                    requestDone,
    output logic                                    busy,
    output logic                                    spanDone,
    fetchIf.sequencer                               fetch
);
    import fbReadPkg::*;

    // Index on offer and pixels left including it
    pixelIdx_t                    curIdx;
    logic [PixelIdxWidth - 1 : 0] remaining;
    // All pixels are out, waiting for the final read request to be taken
    logic                         draining;

    assign fetch.dest = curIdx;
    assign fetch.last = (remaining == 1);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            draining <= 1'b0;
            spanDone <= 1'b0;
            fetch.valid <= 1'b0;
        end
        else
        begin
            spanDone <= 1'b0;
            if (!busy)
            begin
                // Load the span, the first index is offered one cycle later
                if (start)
                begin
                    busy <= 1'b1;
                    curIdx <= spanStart;
                    remaining <= spanLength;
                end
            end
            else if (draining)
            begin
                // The generator flags the handshake of the request that closes the stream
                if (requestDone)
                begin
                    draining <= 1'b0;
                    busy <= 1'b0;
                    spanDone <= 1'b1;
                end
            end
            else if (!fetch.valid)
            begin
                fetch.valid <= 1'b1;
            end
            else if (fetch.ready)
            begin
                if (fetch.last)
                begin
                    // Stop offering once the last index has been taken
                    fetch.valid <= 1'b0;
                    draining <= 1'b1;
                end
                else
                begin
                    curIdx.flat <= curIdx.flat + 1'b1;
                    remaining <= remaining - 1'b1;
                end
            end
        end
    end

    // A stalled offer must not change or disappear before the generator takes it
    fetchHold: assert property (@(posedge aclk) disable iff (!resetn)
        fetch.valid && !fetch.ready |=>
            fetch.valid && $stable(fetch.dest) && $stable(fetch.last))
        else $error("fetch offer changed while stalled");

endmodule

//--- vlog.f
common/fbReadPkg.sv
common/fetchIf.sv
common/memReadIf.sv
verilog/fbReadConfig.sv
verilog/spanFetchSequencer.sv
memReadRequestGenerator/memReadRequestGenerator.sv
verilog/fbReadTop.sv
tb/fbReadTopTb.sv
